// File: test/fetch_input.txt
# Columns, all hex: F base count | L addr data | T id count rnd_ready event at arg
# Events: 0 none, 1 redirect to arg, 2 stall arg cycles, 3 memory stall, 4 divider stall
F 80000000 100
L 80000000 00000013
L 80000004 00100093
L 80000008 00208113
L 8000000c 00310193
L 80000010 00418213
L 80000200 0000006f
L 80000204 fe010113
L 80000208 00112e23
T 2 0c 0 0 0 0
T 3 18 1 0 0 0
T 4 10 1 1 5 80000200
T 5 0c 0 2 4 8
T 6 0c 0 3 4 0
T 7 0c 0 4 4 6

// File: build.f
common/fetch_pkg.sv
fetch/instruction_memory.sv
fetch/instruction_fetch.sv
src/imem_loader.sv
src/fetch_queue.sv
src/fetch_top.sv
test/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - common/fetch_pkg.sv
  - fetch/instruction_memory.sv
  - fetch/instruction_fetch.sv
  - src/imem_loader.sv
  - src/fetch_queue.sv
  - src/fetch_top.sv
  - target: test
    files:
      - test/fetch_tb.sv

// File: test/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

   localparam logic [31:0] start_addr = 32'h8000_0000;
   localparam int depth_log2 = 8;

   logic                  clk;
   logic                  arst_n;
   logic                  run;
   fetch_pkg::stall_t     stall_in;
   logic                  div_ready;
   logic                  redirect_en;
   logic [31:0]           redirect_pc;
   logic                  load_req;
   fetch_pkg::imem_wr_t   load_wr;
   logic                  load_ack;
   logic                  out_valid;
   fetch_pkg::fetch_pkt_t out_pkt;
   logic                  out_ready;

   logic [31:0] model [1 << depth_log2];
   logic [31:0] ld_addr [$];
   logic [31:0] ld_data [$];
   logic [31:0] t_id [$];
   logic [31:0] t_count [$];
   logic [31:0] t_rnd [$];
   logic [31:0] t_event [$];
   logic [31:0] t_at [$];
   logic [31:0] t_arg [$];
   logic [31:0] exp_pc;
   int          rx_count;
   int          idle_cycles;
   int          we_count;
   int          errors;
   int          checks;
   int          tests_passed;
   int          tests_failed;
   int          limit_cycles;
   integer      seed;

   fetch_top #(
      .start_addr       (start_addr),
      .imem_depth_log2  (depth_log2),
      .queue_depth      (4),
      .mem_stall_cycles (2)
   ) dut_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .run         (run),
      .stall_in    (stall_in),
      .div_ready   (div_ready),
      .redirect_en (redirect_en),
      .redirect_pc (redirect_pc),
      .load_req    (load_req),
      .load_wr     (load_wr),
      .load_ack    (load_ack),
      .out_valid   (out_valid),
      .out_pkt     (out_pkt),
      .out_ready   (out_ready)
   );

   always #10 clk = ~clk;

   task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
   endfunction

   task read_input;
      integer           fd;
      integer           n;
      int               i;
      logic [63:0]      cmd;
      logic [8*128-1:0] line;
      logic [31:0]      a, b, c, d, e, f;
      fd = $fopen("test/fetch_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open the input file test/fetch_input.txt");
      end else begin
         cmd = '0;
         n = $fscanf(fd, "%s", cmd);
         while (n == 1) begin
            if (cmd == "#") begin
               n = $fgets(line, fd);
            end else if (cmd == "F") begin
               n = $fscanf(fd, "%h %h", a, b);
               for (i = 0; i < b; i++) begin
                  ld_addr.push_back(a + 4 * i);
                  ld_data.push_back(fill_pattern(a + 4 * i));
               end
            end else if (cmd == "L") begin
               n = $fscanf(fd, "%h %h", a, b);
               ld_addr.push_back(a);
               ld_data.push_back(b);
            end else if (cmd == "T") begin
               n = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
               t_id.push_back(a);
               t_count.push_back(b);
               t_rnd.push_back(c);
               t_event.push_back(d);
               t_at.push_back(e);
               t_arg.push_back(f);
            end else begin
               errors++;
               $display("Unknown command in the input file");
            end
            cmd = '0;
            n = $fscanf(fd, "%s", cmd);
         end
         $fclose(fd);
      end
   endtask

   // One word through the four-phase port
   task load_word(input logic [31:0] addr, input logic [31:0] data);
      int n;
      @(posedge clk);
      #2;
      load_wr  = '{addr: addr, data: data};
      load_req = 1'b1;
      model[addr[depth_log2+1:2]] = data;
      n = 0;
      @(negedge clk);
      while (!load_ack && n < 16) begin
         n++;
         @(negedge clk);
      end
      if (!load_ack) begin
         errors++;
         $display("Load handshake: ack never rose for address %h", addr);
      end
      check_value(n, 2, "cycles from req to ack");
      @(posedge clk);
      #2;
      check_value(load_ack, 1'b1, "ack held until req falls");
      load_req = 1'b0;
      n = 0;
      @(negedge clk);
      while (load_ack && n < 16) begin
         n++;
         @(negedge clk);
      end
      check_value(n, 1, "cycles from req fall to ack fall");
   endtask

   task report_test(input int id, input int items, input int err_mark);
      if (errors == err_mark) begin
         tests_passed++;
         $display("Test %0d: %0d items, passed", id, items);
      end else begin
         tests_failed++;
         $display("Test %0d: %0d items, failed", id, items);
      end
   endtask

   task run_test(input int t);
      int     base;
      int     hold;
      int     idle_mark;
      int     err_mark;
      integer r;
      logic   fired;
      base      = rx_count;
      err_mark  = errors;
      hold      = 0;
      idle_mark = idle_cycles;
      fired     = 1'b0;
      while (rx_count - base < t_count[t]) begin
         @(posedge clk);
         #2;
         redirect_en = 1'b0;
         r = $random(seed);
         out_ready = (t_rnd[t] != 0) ? r[0] : 1'b1;
         if (hold > 0) begin
            hold--;
            if (hold == 0) begin
               stall_in  = '0;
               div_ready = (t_event[t] == 4);
            end
         end else begin
            div_ready = 1'b0;
         end
         if (!fired && rx_count - base == t_at[t]) begin
            fired     = 1'b1;
            idle_mark = idle_cycles;
            case (t_event[t])
               1: begin
                  // Nothing may transfer in the flush cycle
                  redirect_en = 1'b1;
                  redirect_pc = t_arg[t];
                  out_ready   = 1'b0;
                  exp_pc      = t_arg[t];
               end
               2: begin
                  stall_in.stall = 1'b1;
                  hold = t_arg[t];
               end
               3: begin
                  stall_in.stall_mem = 1'b1;
                  hold = 1;
               end
               4: begin
                  stall_in.stall_div = 1'b1;
                  hold = t_arg[t];
               end
               default: begin
               end
            endcase
         end
      end
      if (t_event[t] >= 2) begin
         check_value(idle_cycles != idle_mark, 1'b1, "stream paused by stall");
      end
      report_test(t_id[t], t_count[t], err_mark);
   endtask

   // Reference stream check at the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         if (dut_i.mem_we) begin
            we_count++;
         end
         if (!out_valid) begin
            idle_cycles++;
         end
         if (out_valid && out_ready) begin
            check_value(out_pkt.pc, exp_pc, "packet pc");
            check_value(out_pkt.insn, model[exp_pc[depth_log2+1:2]], "packet insn");
            exp_pc = exp_pc + 32'd4;
            rx_count++;
         end
      end
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      int i;
      int total;
      int mark;
      clk         = 1'b0;
      arst_n      = 1'b0;
      run         = 1'b0;
      stall_in    = '0;
      div_ready   = 1'b0;
      redirect_en = 1'b0;
      redirect_pc = '0;
      load_req    = 1'b0;
      load_wr     = '0;
      out_ready   = 1'b0;
      exp_pc      = start_addr;
      seed        = 32'h995c380b;
      read_input();
      total = 0;
      for (i = 0; i < t_count.size(); i++) begin
         total += t_count[i];
      end
      limit_cycles = total * 40 + ld_addr.size() * 10 + 100;
      repeat (4) @(posedge clk);
      #2;
      arst_n = 1'b1;
      mark = errors;
      // Nothing pending out of reset
      check_value(out_valid, 1'b0, "out_valid after reset");
      check_value(load_ack, 1'b0, "load_ack after reset");
      for (i = 0; i < ld_addr.size(); i++) begin
         load_word(ld_addr[i], ld_data[i]);
      end
      check_value(we_count, ld_addr.size(), "memory write pulses");
      report_test(1, ld_addr.size(), mark);
      @(posedge clk);
      #2;
      run = 1'b1;
      for (i = 0; i < t_count.size(); i++) begin
         run_test(i);
      end
      @(posedge clk);
      #2;
      out_ready = 1'b0;
      stall_in  = '0;
      repeat (4) @(posedge clk);
      $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
               tests_passed, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
   parameter logic [fetch_pkg::xlen-1:0] start_addr = 32'h8000_0000,
   parameter int imem_depth_log2 = 8,
   parameter int queue_depth = 4,
   parameter int mem_stall_cycles = 2
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         run,
   input  fetch_pkg::stall_t            stall_in,
   input  logic                         div_ready,
   input  logic                         redirect_en,
   input  logic [fetch_pkg::xlen-1:0]   redirect_pc,
   input  logic                         load_req,
   input  fetch_pkg::imem_wr_t          load_wr,
   output logic                         load_ack,
   output logic                         out_valid,
   output fetch_pkg::fetch_pkt_t        out_pkt,
   input  logic                         out_ready
);

   logic                  mem_we;
   fetch_pkg::imem_wr_t   mem_wr;
   logic                  pkt_valid;
   fetch_pkg::fetch_pkt_t pkt;
   logic                  flush;
   logic                  full;

   imem_loader loader_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .load_req (load_req),
      .load_wr  (load_wr),
      .load_ack (load_ack),
      .mem_we   (mem_we),
      .mem_wr   (mem_wr)
   );

   instruction_fetch #(
      .start_addr       (start_addr),
      .imem_depth_log2  (imem_depth_log2),
      .mem_stall_cycles (mem_stall_cycles)
   ) fetch_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .run         (run),
      .stall_in    (stall_in),
      .div_ready   (div_ready),
      .redirect_en (redirect_en),
      .redirect_pc (redirect_pc),
      .full        (full),
      .mem_we      (mem_we),
      .mem_wr      (mem_wr),
      .pkt_valid   (pkt_valid),
      .pkt         (pkt),
      .flush       (flush)
   );

   fetch_queue #(
      .queue_depth (queue_depth)
   ) queue_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .flush     (flush),
      .in_valid  (pkt_valid),
      .in_pkt    (pkt),
      .full      (full),
      .out_valid (out_valid),
      .out_pkt   (out_pkt),
      .out_ready (out_ready)
   );

endmodule

// File: src/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue #(
   parameter int queue_depth = 4
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   flush,
   input  logic                   in_valid,
   input  fetch_pkg::fetch_pkt_t  in_pkt,
   output logic                   full,
   output logic                   out_valid,
   output fetch_pkg::fetch_pkt_t  out_pkt,
   input  logic                   out_ready
);

   localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
   localparam int cnt_w = $clog2(queue_depth + 1);

   fetch_pkg::fetch_pkt_t slots [queue_depth];
   logic [ptr_w-1:0]      wr_ptr;
   logic [ptr_w-1:0]      rd_ptr;
   logic [cnt_w-1:0]      count;
   logic                  push;
   logic                  pop;

   // Pointer wrap for any depth
   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
      if (p == ptr_w'(queue_depth - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   assign full      = (count == cnt_w'(queue_depth));
   assign out_valid = (count != '0);
   assign out_pkt   = slots[rd_ptr];
   assign push      = in_valid && !full;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push && !flush) begin
         slots[wr_ptr] <= in_pkt;
      end
   end

   no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
      in_valid |-> !full);

   out_stable: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready && !flush |=> $stable(out_pkt));

endmodule

// File: src/imem_loader.sv
`timescale 1ns/1ns

module imem_loader (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 load_req,
   input  fetch_pkg::imem_wr_t  load_wr,
   output logic                 load_ack,
   output logic                 mem_we,
   output fetch_pkg::imem_wr_t  mem_wr
);

   typedef enum logic [1:0] {ld_idle, ld_write, ld_ack} ld_state_t;

   ld_state_t state;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= ld_idle;
         mem_we   <= 1'b0;
         load_ack <= 1'b0;
      end else begin
         case (state)
            ld_idle: begin
               if (load_req) begin
                  mem_we <= 1'b1;
                  state  <= ld_write;
               end
            end
            ld_write: begin
               // Write lands this cycle, ack follows
               mem_we   <= 1'b0;
               load_ack <= 1'b1;
               state    <= ld_ack;
            end
            ld_ack: begin
               if (!load_req) begin
                  load_ack <= 1'b0;
                  state    <= ld_idle;
               end
            end
            default: begin
               state <= ld_idle;
            end
         endcase
      end
   end

   // Capture address and data with the request
   always_ff @(posedge clk) begin
      if (state == ld_idle && load_req) begin
         mem_wr <= load_wr;
      end
   end

   req_before_ack: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(load_req) |-> load_ack);

endmodule

// File: fetch/instruction_fetch.sv
`timescale 1ns/1ns

module instruction_fetch #(
   parameter logic [fetch_pkg::xlen-1:0] start_addr = 32'h8000_0000,
   parameter int imem_depth_log2 = 8,
   parameter int mem_stall_cycles = 2
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         run,
   input  fetch_pkg::stall_t            stall_in,
   input  logic                         div_ready,
   input  logic                         redirect_en,
   input  logic [fetch_pkg::xlen-1:0]   redirect_pc,
   input  logic                         full,
   input  logic                         mem_we,
   input  fetch_pkg::imem_wr_t          mem_wr,
   output logic                         pkt_valid,
   output fetch_pkg::fetch_pkt_t        pkt,
   output logic                         flush
);

   localparam int cnt_w = $clog2(mem_stall_cycles + 1);

   typedef enum logic [1:0] {st_idle, st_run, st_wait, st_redirect} state_t;

   state_t                     state;
   logic [fetch_pkg::xlen-1:0] pc;
   logic [fetch_pkg::xlen-1:0] rd_pc;
   logic [fetch_pkg::xlen-1:0] rd_insn;
   logic [fetch_pkg::xlen-1:0] fetch_addr;
   logic                       rd_valid;
   logic                       stall_mem_q;
   logic                       mem_rise;
   logic                       div_wait;
   logic                       advance;
   logic [cnt_w-1:0]           mem_cnt;

   // Memory stall acts on its rising edge only
   assign mem_rise = stall_in.stall_mem && !stall_mem_q;
   assign flush    = redirect_en && (state != st_idle);

   assign advance = (state == st_run) && !flush && !full && !stall_in.stall &&
                    !mem_rise && !stall_in.stall_div;

   assign pkt_valid = rd_valid && !full && !flush;
   assign pkt       = '{pc: rd_pc, insn: rd_insn};

   // While the queue is full keep reading the held word so rd_insn stays valid
   assign fetch_addr = (rd_valid && full) ? rd_pc : pc;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= st_idle;
         pc          <= start_addr;
         stall_mem_q <= 1'b0;
         mem_cnt     <= '0;
         div_wait    <= 1'b0;
      end else begin
         stall_mem_q <= stall_in.stall_mem;
         if (flush) begin
            state    <= st_redirect;
            pc       <= redirect_pc;
            mem_cnt  <= '0;
            div_wait <= 1'b0;
         end else begin
            case (state)
               st_idle: begin
                  if (run) begin
                     state <= st_run;
                  end
               end
               st_run: begin
                  if (advance) begin
                     pc <= pc + fetch_pkg::insn_step;
                  end
                  if (mem_rise) begin
                     mem_cnt <= cnt_w'(mem_stall_cycles - 1);
                  end
                  if (stall_in.stall_div && !div_ready) begin
                     div_wait <= 1'b1;
                  end
                  if ((mem_rise && mem_stall_cycles > 1) ||
                      (stall_in.stall_div && !div_ready)) begin
                     state <= st_wait;
                  end
               end
               st_wait: begin
                  if (mem_cnt != '0) begin
                     mem_cnt <= mem_cnt - 1'b1;
                  end
                  if (div_ready) begin
                     div_wait <= 1'b0;
                  end
                  // Leave once the memory count runs out and the divider is done
                  if (mem_cnt <= cnt_w'(1) && (!div_wait || div_ready)) begin
                     state <= st_run;
                  end
               end
               st_redirect: begin
                  state <= st_run;
               end
               default: begin
                  state <= st_idle;
               end
            endcase
         end
      end
   end

   // Read in flight, dropped on redirect
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid <= 1'b0;
      end else if (flush) begin
         rd_valid <= 1'b0;
      end else if (advance) begin
         rd_valid <= 1'b1;
      end else if (pkt_valid) begin
         rd_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         rd_pc <= pc;
      end
   end

   instruction_memory #(
      .imem_depth_log2(imem_depth_log2)
   ) imem_i (
      .clk     (clk),
      .rd_addr (fetch_addr),
      .rd_insn (rd_insn),
      .we      (mem_we),
      .wr      (mem_wr)
   );

   // Dropped read and redirect cycle give no packet
   pkt_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !pkt_valid [*2]);

endmodule

// File: fetch/instruction_memory.sv
`timescale 1ns/1ns

module instruction_memory #(
   parameter int imem_depth_log2 = 8
) (
   input  logic                         clk,
   input  logic [fetch_pkg::xlen-1:0]   rd_addr,
   output logic [fetch_pkg::xlen-1:0]   rd_insn,
   input  logic                         we,
   input  fetch_pkg::imem_wr_t          wr
);

   localparam int depth = 1 << imem_depth_log2;

   logic [fetch_pkg::xlen-1:0] words [depth];
   logic [imem_depth_log2-1:0] rd_idx;
   logic [imem_depth_log2-1:0] wr_idx;

   // Word index, byte offset dropped
   assign rd_idx = rd_addr[imem_depth_log2+1:2];
   assign wr_idx = wr.addr[imem_depth_log2+1:2];

   always_ff @(posedge clk) begin
      if (we) begin
         words[wr_idx] <= wr.data;
      end
   end

   // Synchronous read, old data on a same-cycle write
   always_ff @(posedge clk) begin
      rd_insn <= words[rd_idx];
   end

endmodule

// File: common/fetch_pkg.sv
package fetch_pkg;

   // Data and address width of the core
   localparam int xlen = 32;

   // Byte step between two sequential instruction words
   localparam logic [xlen-1:0] insn_step = 32'd4;

   // Fetched instruction and the pc it came from
   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [xlen-1:0] insn;
   } fetch_pkt_t;

   // One instruction memory write, byte address and word
   typedef struct packed {
      logic [xlen-1:0] addr;
      logic [xlen-1:0] data;
   } imem_wr_t;

   // Stall sources seen by fetch
   typedef struct packed {
      logic stall;
      logic stall_mem;
      logic stall_div;
   } stall_t;

endpackage
